//--- arith_pkg.sv
// Arithmetic unit package.
// Holds the operand widths, the opcode set and the request and result records.
package arith_pkg;

    // Operand width. Every request operand is one byte.
    localparam int DATA_W = 8;

    // Result width, wide enough for a full product.
    localparam int RES_W = 2 * DATA_W;

    // Largest natural multiply-add result, (2^N-1)*(2^N-1) + (2^N-1).
    localparam int MUL_ADD_MAX = ((2 ** DATA_W) - 1) * ((2 ** DATA_W) - 1) + (2 ** DATA_W) - 1;

    // Opcodes accepted by the core.
    // Code 3'd7 is unused and never valid in a stored request.
    typedef enum logic [2:0] {
        OP_ADD     = 3'd0,
        OP_SUB     = 3'd1,
        OP_MUL_ADD = 3'd2,
        OP_IMUL    = 3'd3,
        OP_CMP     = 3'd4,
        OP_TO_SM   = 3'd5,
        OP_FROM_SM = 3'd6
    } op_e;

    // One request as it arrives with the start strobe.
    // The cin bit is the carry in for OP_ADD, the borrow in for OP_SUB
    // and the sign for OP_FROM_SM. The c operand is only read by OP_MUL_ADD.
    typedef struct packed {
        op_e               op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] c;
        logic              cin;
    } arith_req_t;

    // Status flags. A flag that has no meaning for an opcode reads zero.
    typedef struct packed {
        logic carry;
        logic ovf;
        logic less;
        logic equal;
        logic sign;
    } arith_flags_t;

    // Result record returned with the done pulse.
    typedef struct packed {
        logic [RES_W-1:0] value;
        arith_flags_t     flags;
    } arith_res_t;

endpackage

//--- addsub_unit.sv
// Adder and subtractor for 8-bit operands.
// Gives carry or borrow out and the signed overflow for the chosen operation.
`timescale 1ns/1ps

module addsub_unit (
    input  logic [arith_pkg::DATA_W-1:0] a,
    input  logic [arith_pkg::DATA_W-1:0] b,
    input  logic                         cin,
    input  logic                         subtract,
    output logic [arith_pkg::DATA_W-1:0] sum,
    output logic                         carry,
    output logic                         ovf
);
    import arith_pkg::*;

    // Index of the sign bit of an operand.
    localparam int MSB = DATA_W - 1;

    // One bit wider than an operand so the top bit carries the carry or borrow.
    logic [DATA_W:0] wide;

    // The carry or borrow in, zero-extended to the wide width.
    logic [DATA_W:0] cin_wide;

    assign cin_wide = {{DATA_W{1'b0}}, cin};

    // Both operations share one wide sum.
    // For subtraction a negative result wraps, so the top bit is the borrow out.
    always_comb begin
        if (subtract) begin
            wide = {1'b0, a} - {1'b0, b} - cin_wide;
        end else begin
            wide = {1'b0, a} + {1'b0, b} + cin_wide;
        end
    end

    assign sum   = wide[DATA_W-1:0];
    assign carry = wide[DATA_W];

    // A sum overflows only when both operands share a sign and the result lost it.
    // A difference overflows only when the operands differ in sign
    // and the result no longer has the sign of the minuend.
    always_comb begin
        if (subtract) begin
            ovf = (a[MSB] != b[MSB]) && (sum[MSB] != a[MSB]);
        end else begin
            ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
        end
    end

endmodule

//--- mul_unit.sv
// Multiplier for 8-bit operands.
// Natural multiply with an addend, or signed multiply through sign and magnitude.
`timescale 1ns/1ps

module mul_unit (
    input  logic [arith_pkg::DATA_W-1:0] a,
    input  logic [arith_pkg::DATA_W-1:0] b,
    input  logic [arith_pkg::DATA_W-1:0] c,
    input  logic                         signed_mode,
    output logic [arith_pkg::RES_W-1:0]  product
);
    import arith_pkg::*;

    // Padding that lifts an operand to the product width.
    localparam int PAD_W = RES_W - DATA_W;

    // Natural path.
    logic [RES_W-1:0] nat_prod;

    // Signed path, split into signs and magnitudes.
    logic              sign_a;
    logic              sign_b;
    logic              sign_p;
    logic [DATA_W-1:0] abs_a;
    logic [DATA_W-1:0] abs_b;
    logic [RES_W-1:0]  abs_prod;
    logic [RES_W-1:0]  signed_prod;

    // The natural result always fits in 16 bits, even for 255 * 255 + 255.
    assign nat_prod = ({{PAD_W{1'b0}}, a} * {{PAD_W{1'b0}}, b}) + {{PAD_W{1'b0}}, c};

    assign sign_a = a[DATA_W-1];
    assign sign_b = b[DATA_W-1];

    // The magnitude of -128 is 8'h80, which still reads correctly as natural 128.
    assign abs_a = sign_a ? (~a + 1'b1) : a;
    assign abs_b = sign_b ? (~b + 1'b1) : b;

    // Multiply the magnitudes as natural numbers.
    assign abs_prod = {{PAD_W{1'b0}}, abs_a} * {{PAD_W{1'b0}}, abs_b};

    // The product is negative when exactly one operand is negative.
    assign sign_p = sign_a ^ sign_b;

    // Negate back into two's complement.
    // The largest magnitude is 128 * 128, which is still positive in 16 bits.
    assign signed_prod = sign_p ? (~abs_prod + 1'b1) : abs_prod;

    always_comb begin
        if (signed_mode) begin
            product = signed_prod;
        end else begin
            product = nat_prod;
        end
    end

    // The natural multiply-add never wraps, so its result stays within range.
    natural_in_range: assert final (signed_mode || (product <= MUL_ADD_MAX))
        else $error("mul_unit: natural product %0d above limit", product);

endmodule

//--- sign_conv_unit.sv
// Sign conversion and compare unit.
// Converts between two's complement and sign-magnitude and compares a and b.
`timescale 1ns/1ps

module sign_conv_unit (
    input  logic [arith_pkg::DATA_W-1:0] a,
    input  logic [arith_pkg::DATA_W-1:0] b,
    input  logic                         sign_in,
    output logic [arith_pkg::DATA_W-1:0] magnitude,
    output logic                         sign_out,
    output logic [arith_pkg::DATA_W-1:0] twos,
    output logic                         conv_ovf,
    output logic                         less,
    output logic                         equal
);
    import arith_pkg::*;

    // Index of the sign bit.
    localparam int MSB = DATA_W - 1;

    // Negated magnitude, used when the sign-magnitude input is negative.
    logic [DATA_W-1:0] neg_a;

    // Reverse conversion of twos, kept only for the round-trip check.
    logic [DATA_W-1:0] back_mag;
    logic              back_sign;

    // Two's complement to sign-magnitude.
    // The sign is the top bit; the magnitude of -128 comes out as 8'h80.
    assign sign_out  = a[MSB];
    assign magnitude = sign_out ? (~a + 1'b1) : a;

    // Sign-magnitude to two's complement.
    // The conversion works from the magnitude input, never from its own output.
    assign neg_a = ~a + 1'b1;

    // Magnitudes above 128 never fit. Exactly 128 fits only as -128.
    assign conv_ovf = a[MSB] & ((|a[MSB-1:0]) | ~sign_in);

    // An unrepresentable value reads as zero.
    always_comb begin
        if (conv_ovf) begin
            twos = '0;
        end else if (sign_in) begin
            twos = neg_a;
        end else begin
            twos = a;
        end
    end

    // Natural comparison.
    assign less  = (a < b);
    assign equal = (a == b);

    // Convert twos back to sign-magnitude.
    assign back_sign = twos[MSB];
    assign back_mag  = back_sign ? (~twos + 1'b1) : twos;

    // Both converters together must be lossless whenever no overflow is flagged.
    // A zero magnitude carries no sign, so the sign is only checked for nonzero a.
    round_trip: assert final (conv_ovf
        || ((back_mag == a) && ((a == '0) || (back_sign == sign_in))))
        else $error("sign_conv_unit: round trip failed for a=%0d sign=%0b", a, sign_in);

endmodule

//--- arith_core.sv
// Two-stage integer arithmetic core.
// Registers a request, selects the unit result by opcode and returns it two cycles later.
`timescale 1ns/1ps

module arith_core (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  start,
    input  arith_pkg::arith_req_t req,
    output logic                  done,
    output arith_pkg::arith_res_t res
);
    import arith_pkg::*;

    // Zero padding that lifts a byte result to the result width.
    localparam int PAD_W = RES_W - DATA_W;

    // Stage one holds the request and whether it is live.
    arith_req_t req_q;
    logic       req_valid;

    // Adder and subtractor outputs.
    logic [DATA_W-1:0] add_sum;
    logic              add_carry;
    logic              add_ovf;
    logic              is_sub;

    // Multiplier outputs.
    logic [RES_W-1:0] mul_product;
    logic             is_imul;

    // Converter and comparator outputs.
    logic [DATA_W-1:0] conv_mag;
    logic              conv_sign;
    logic [DATA_W-1:0] conv_twos;
    logic              conv_ovf;
    logic              cmp_less;
    logic              cmp_equal;

    // Selected result before it is registered.
    arith_res_t sel_res;

    // Stage one.
    // The valid bit follows start every cycle, so a request can be issued back to back.
    always_ff @(posedge clock) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= start;
        end
    end

    // The payload only changes when a new request arrives.
    always_ff @(posedge clock) begin
        if (start) begin
            req_q <= req;
        end
    end

    // Operation selects for the shared units.
    assign is_sub  = (req_q.op == OP_SUB);
    assign is_imul = (req_q.op == OP_IMUL);

    addsub_unit u_addsub (
        .a        (req_q.a),
        .b        (req_q.b),
        .cin      (req_q.cin),
        .subtract (is_sub),
        .sum      (add_sum),
        .carry    (add_carry),
        .ovf      (add_ovf)
    );

    mul_unit u_mul (
        .a           (req_q.a),
        .b           (req_q.b),
        .c           (req_q.c),
        .signed_mode (is_imul),
        .product     (mul_product)
    );

    // For OP_FROM_SM the cin bit carries the sign of the magnitude in a.
    sign_conv_unit u_sign_conv (
        .a         (req_q.a),
        .b         (req_q.b),
        .sign_in   (req_q.cin),
        .magnitude (conv_mag),
        .sign_out  (conv_sign),
        .twos      (conv_twos),
        .conv_ovf  (conv_ovf),
        .less      (cmp_less),
        .equal     (cmp_equal)
    );

    // Result selection.
    // Start from all zeros so unused flags and upper value bits stay clear.
    always_comb begin
        sel_res = '0;
        case (req_q.op)
            OP_ADD, OP_SUB: begin
                sel_res.value       = {{PAD_W{1'b0}}, add_sum};
                sel_res.flags.carry = add_carry;
                sel_res.flags.ovf   = add_ovf;
            end
            OP_MUL_ADD: begin
                sel_res.value = mul_product;
            end
            OP_IMUL: begin
                // The sign flag mirrors the top bit of the signed product.
                sel_res.value      = mul_product;
                sel_res.flags.sign = mul_product[RES_W-1];
            end
            OP_CMP: begin
                sel_res.flags.less  = cmp_less;
                sel_res.flags.equal = cmp_equal;
            end
            OP_TO_SM: begin
                sel_res.value      = {{PAD_W{1'b0}}, conv_mag};
                sel_res.flags.sign = conv_sign;
            end
            OP_FROM_SM: begin
                // The converter already forces the value to zero on overflow.
                sel_res.value     = {{PAD_W{1'b0}}, conv_twos};
                sel_res.flags.ovf = conv_ovf;
            end
            default: begin
                sel_res = '0;
            end
        endcase
    end

    // Stage two.
    // The result holds its last value between requests and starts out zero.
    always_ff @(posedge clock) begin
        if (rst) begin
            done <= 1'b0;
            res  <= '0;
        end else begin
            done <= req_valid;
            if (req_valid) begin
                res <= sel_res;
            end
        end
    end

    // Once out of reset the done pulse is always a clean 0 or 1.
    done_known: assert property (@(posedge clock) disable iff (rst) !$isunknown(done))
        else $error("arith_core: done is unknown");

    // Every start gives a done exactly two edges later, and no start gives none.
    done_after_start: assert property (@(posedge clock) disable iff (rst) start |-> ##2 done)
        else $error("arith_core: done missing two cycles after start");
    no_stray_done: assert property (@(posedge clock) disable iff (rst) !start |-> ##2 !done)
        else $error("arith_core: done without a start two cycles before");

    // A live request always carries one of the seven defined opcodes.
    op_legal: assert property (@(posedge clock) disable iff (rst)
        req_valid |-> (req_q.op inside {OP_ADD, OP_SUB, OP_MUL_ADD, OP_IMUL,
                                        OP_CMP, OP_TO_SM, OP_FROM_SM}))
        else $error("arith_core: illegal opcode %0d stored", req_q.op);

endmodule

//--- tb_arith_core.sv
// Testbench for the two-stage arithmetic core.
// Runs directed tests per opcode group and a back-to-back burst against a reference model.
`timescale 1ns/1ps

module tb_arith_core;
    import arith_pkg::*;

    // Longest wait for a done pulse, in clock cycles.
    localparam int WAIT_LIMIT = 10;

    // Number of requests in the back-to-back burst.
    localparam int BURST_LEN = 20;

    logic       clock;
    logic       rst;
    logic       start;
    arith_req_t req;
    logic       done;
    arith_res_t res;

    // Error counters, one per kind of check.
    int value_errors;
    int flag_errors;
    int other_errors;

    // State of the random source.
    logic [31:0] lfsr_state;

    arith_core dut0 (
        .clock (clock),
        .rst   (rst),
        .start (start),
        .req   (req),
        .done  (done),
        .res   (res)
    );

    // 20 ns clock period.
    initial clock = 1'b0;
    always #10 clock = ~clock;

    // Fibonacci LFSR with taps 32, 22, 2 and 1. Each call yields one new bit.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            v = {v[6:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic arith_req_t make_req(input op_e op, input logic [7:0] a,
                                            input logic [7:0] b, input logic [7:0] c,
                                            input logic cin);
        arith_req_t r;
        r.op  = op;
        r.a   = a;
        r.b   = b;
        r.c   = c;
        r.cin = cin;
        return r;
    endfunction

    // Random request with any of the seven opcodes.
    function automatic arith_req_t random_request();
        logic [2:0] code;
        arith_req_t r;
        code = '0;
        for (int i = 0; i < 3; i++) begin
            code = {code[1:0], lfsr_bit()};
        end
        r.op  = op_e'(code % 3'd7);
        r.a   = rand_byte();
        r.b   = rand_byte();
        r.c   = rand_byte();
        r.cin = lfsr_bit();
        return r;
    endfunction

    // Reference model. Works on plain integers and then applies the flag rules.
    function automatic arith_res_t expected_result(input arith_req_t r);
        arith_res_t e;
        int         total;
        logic [31:0] bits;
        e = '0;
        case (r.op)
            OP_ADD: begin
                total = int'(r.a) + int'(r.b) + int'(r.cin);
                bits = total;
                e.value = {8'h00, bits[7:0]};
                e.flags.carry = bits[8];
                e.flags.ovf = (r.a[7] == r.b[7]) && (bits[7] != r.a[7]);
            end
            OP_SUB: begin
                total = int'(r.a) - int'(r.b) - int'(r.cin);
                bits = total;
                e.value = {8'h00, bits[7:0]};
                e.flags.carry = (total < 0);
                e.flags.ovf = (r.a[7] != r.b[7]) && (bits[7] != r.a[7]);
            end
            OP_MUL_ADD: begin
                total = int'(r.a) * int'(r.b) + int'(r.c);
                bits = total;
                e.value = bits[15:0];
            end
            OP_IMUL: begin
                total = int'($signed(r.a)) * int'($signed(r.b));
                bits = total;
                e.value = bits[15:0];
                e.flags.sign = bits[15];
            end
            OP_CMP: begin
                e.flags.less  = (int'(r.a) < int'(r.b));
                e.flags.equal = (r.a == r.b);
            end
            OP_TO_SM: begin
                // A negative byte has magnitude 256 - a, so -128 gives 128.
                total = r.a[7] ? (256 - int'(r.a)) : int'(r.a);
                bits = total;
                e.value = {8'h00, bits[7:0]};
                e.flags.sign = r.a[7];
            end
            OP_FROM_SM: begin
                e.flags.ovf = (int'(r.a) > 128) || ((int'(r.a) == 128) && !r.cin);
                if (!e.flags.ovf) begin
                    total = r.cin ? (256 - int'(r.a)) : int'(r.a);
                    bits = total;
                    e.value = {8'h00, bits[7:0]};
                end
            end
            default: begin
                e = '0;
            end
        endcase
        return e;
    endfunction

    task automatic check_value(input string name, input logic [RES_W-1:0] got,
                               input logic [RES_W-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flags(input string name, input arith_flags_t got,
                               input arith_flags_t exp);
        if (got !== exp) begin
            flag_errors++;
            $display("Error at %0t: %s (carry ovf less equal sign) is %b, expected %b",
                     $time, name, got, exp);
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp) begin
            other_errors++;
            $display("Error at %0t: done is %b, expected %b", $time, got, exp);
        end
    endtask

    // Issues one request, waits for its done and checks the result.
    task automatic run_request(input arith_req_t r);
        arith_res_t exp;
        int         cycles;
        exp = expected_result(r);
        @(negedge clock);
        start = 1'b1;
        req   = r;
        @(negedge clock);
        start  = 1'b0;
        cycles = 1;
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!done) begin
            other_errors++;
            $display("No done within %0d cycles for %s at %0t", WAIT_LIMIT, r.op.name(), $time);
        end else begin
            if (cycles != 2) begin
                other_errors++;
                $display("Done for %s came %0d cycles after start instead of 2 at %0t",
                         r.op.name(), cycles, $time);
            end
            check_value("res.value", res.value, exp.value);
            check_flags("res.flags", res.flags, exp.flags);
        end
    endtask

    // Outputs must stay quiet after reset until the first request.
    task automatic idle_after_reset();
        for (int i = 0; i < 4; i++) begin
            @(negedge clock);
            check_done(done, 1'b0);
            check_value("res.value", res.value, '0);
            check_flags("res.flags", res.flags, '0);
        end
    endtask

    task automatic add_sub_corners();
        op_e op;
        run_request(make_req(OP_ADD, 8'd127, 8'd1, 8'd0, 1'b0));
        run_request(make_req(OP_SUB, 8'h80, 8'd1, 8'd0, 1'b0));
        run_request(make_req(OP_ADD, 8'd255, 8'd1, 8'd0, 1'b1));
        run_request(make_req(OP_SUB, 8'd0, 8'd1, 8'd0, 1'b1));
        for (int i = 0; i < 40; i++) begin
            op = lfsr_bit() ? OP_SUB : OP_ADD;
            run_request(make_req(op, rand_byte(), rand_byte(), 8'd0, lfsr_bit()));
        end
    endtask

    task automatic multiply_products();
        run_request(make_req(OP_MUL_ADD, 8'd255, 8'd255, 8'd255, 1'b0));
        for (int i = 0; i < 10; i++) begin
            run_request(make_req(OP_MUL_ADD, rand_byte(), rand_byte(), rand_byte(), 1'b0));
        end
        run_request(make_req(OP_IMUL, 8'h80, 8'h80, 8'd0, 1'b0));
        run_request(make_req(OP_IMUL, 8'hff, 8'h7f, 8'd0, 1'b0));
        for (int i = 0; i < 10; i++) begin
            run_request(make_req(OP_IMUL, rand_byte(), rand_byte(), 8'd0, 1'b0));
        end
    endtask

    task automatic compare_and_convert();
        logic [7:0] mags [4];
        mags = '{8'd0, 8'd127, 8'd128, 8'd200};
        run_request(make_req(OP_CMP, 8'd77, 8'd77, 8'd0, 1'b0));
        run_request(make_req(OP_CMP, 8'd3, 8'd200, 8'd0, 1'b0));
        run_request(make_req(OP_CMP, 8'd200, 8'd3, 8'd0, 1'b0));
        run_request(make_req(OP_TO_SM, 8'd0, 8'd0, 8'd0, 1'b0));
        run_request(make_req(OP_TO_SM, 8'd127, 8'd0, 8'd0, 1'b0));
        run_request(make_req(OP_TO_SM, 8'h80, 8'd0, 8'd0, 1'b0));
        for (int i = 0; i < 4; i++) begin
            run_request(make_req(OP_FROM_SM, mags[i], 8'd0, 8'd0, 1'b0));
            run_request(make_req(OP_FROM_SM, mags[i], 8'd0, 8'd0, 1'b1));
        end
    endtask

    // A new request every cycle. done must track start two cycles later
    // and the results must come back in issue order.
    task automatic back_to_back_burst();
        arith_res_t exp_q[$];
        arith_res_t exp;
        arith_req_t r;
        logic [1:0] start_hist;
        int         sent;
        int         received;
        int         cycles;
        sent       = 0;
        received   = 0;
        cycles     = 0;
        start_hist = 2'b00;
        while (received < BURST_LEN && cycles < BURST_LEN + WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
            check_done(done, start_hist[1]);
            if (done) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("A result arrived with no request outstanding at %0t", $time);
                end else begin
                    exp = exp_q.pop_front();
                    check_value("res.value", res.value, exp.value);
                    check_flags("res.flags", res.flags, exp.flags);
                    received++;
                end
            end
            if (sent < BURST_LEN) begin
                r     = random_request();
                start = 1'b1;
                req   = r;
                exp_q.push_back(expected_result(r));
                sent++;
            end else begin
                start = 1'b0;
            end
            start_hist = {start_hist[0], start};
        end
        if (received < BURST_LEN) begin
            other_errors++;
            $display("Burst timed out with %0d of %0d results at %0t",
                     received, BURST_LEN, $time);
        end
        // With start low, no further done may appear.
        for (int i = 0; i < 2; i++) begin
            @(negedge clock);
            check_done(done, 1'b0);
        end
    endtask

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        req          = '0;
        lfsr_state   = 32'h2548_b409;
        value_errors = 0;
        flag_errors  = 0;
        other_errors = 0;

        // Five rising edges in reset, then release on a falling edge.
        repeat (5) @(negedge clock);
        rst = 1'b0;

        idle_after_reset();
        add_sub_corners();
        multiply_products();
        compare_and_convert();
        back_to_back_burst();

        $display("Checks done: value errors %0d, flag errors %0d, other errors %0d",
                 value_errors, flag_errors, other_errors);
        if (value_errors + flag_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- compile.f
arith_pkg.sv
addsub_unit.sv
mul_unit.sv
sign_conv_unit.sv
arith_core.sv
tb_arith_core.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the arithmetic core testbench with Verilator and runs it.
# Exits with status 0 only when the testbench reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module tb_arith_core \
    --Mdir obj_dir \
    -o sim_arith_core

output=$(./obj_dir/sim_arith_core 2>&1)
echo "$output"

if grep -q "Testbench passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
